/* elink_tx.f */
src/emesh_pkg.sv
src/elink_cfg_pkg.sv
src/elink_cfg_regs.sv
src/tx_write_fifo.sv
src/elink_tx_top.sv
sim/elink_tx_tb.sv

/* Bender.yml */
package:
  name: elink_tx

sources:
  # packages first, then the design bottom up
  - files:
      - src/emesh_pkg.sv
      - src/elink_cfg_pkg.sv
      - src/elink_cfg_regs.sv
      - src/tx_write_fifo.sv
      - src/elink_tx_top.sv

  # testbench, top module elink_tx_tb
  - target: test
    files:
      - sim/elink_tx_tb.sv

/* sim/elink_tx_tb.sv */
// directed testbench for the tx config front end
// clock, reset, xorshift stimulus, compare tasks, six tests, timeout
`timescale 1ns/1ps
`default_nettype none

module elink_tx_tb;

   import emesh_pkg::*;
   import elink_cfg_pkg::*;

   localparam int          MAX_CYCLES = 2000;  // roughly 3x all tests together
   localparam logic [31:0] SEED       = 32'hde0b8431;

   logic          clk;
   logic          reset;
   logic          in_valid;
   logic          in_ready;
   emesh_packet_t in_packet;
   logic          out_valid;
   logic          out_ready;
   emesh_packet_t out_packet;
   logic          elink_en;
   clk_config_t   clk_config;
   chipid_t       chipid;

   // reference model
   emesh_packet_t exp_q[$];     // forwarded packets, oldest first
   logic          exp_en;
   clk_config_t   exp_clk;
   chipid_t       exp_chipid;

   logic [31:0] data_state;     // stimulus random state
   logic [31:0] ready_state;    // out_ready random state
   logic [1:0]  ready_mode;     // 0 ready, 1 stalled, 2 random
   int          cycle_count;
   int          check_count;
   int          error_count;
   int          test_count;

   elink_tx_top dut (
      .clk        (clk),
      .reset      (reset),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .in_packet  (in_packet),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_packet (out_packet),
      .elink_en   (elink_en),
      .clk_config (clk_config),
      .chipid     (chipid)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;  // 4 ns period
   end

   // ########################################
   // stimulus helpers
   // ########################################

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] rand_word();
      data_state = xorshift32(data_state);
      return data_state;
   endfunction

   // own decode of the config write rule
   function automatic logic is_cfg_write(input emesh_packet_t p);
      reg_idx_t idx;
      idx = p.dstaddr[7:2];
      return p.write && (p.dstaddr[31:20] == ELINK_ID) && (p.dstaddr[10:8] == CFG_GROUP) &&
             (idx == REG_RESET || idx == REG_CLK || idx == REG_CHIPID);
   endfunction

   function automatic emesh_addr_t build_addr(input logic [11:0] id, input logic [2:0] grp,
                                              input reg_idx_t idx);
      return {id, 9'h000, grp, idx, 2'b00};
   endfunction

   function automatic emesh_packet_t make_packet(input logic wr, input emesh_addr_t dst,
                                                 input logic [31:0] data);
      emesh_packet_t p;
      logic [31:0]   r;
      r = rand_word();
      p.write    = wr;
      p.datamode = r[1:0];
      p.ctrlmode = r[6:2];
      p.dstaddr  = dst;
      p.data     = data;
      p.srcaddr  = rand_word();
      return p;
   endfunction

   // anything outside this node's id is never absorbed
   function automatic emesh_packet_t random_packet();
      emesh_addr_t dst;
      dst = rand_word();
      if (dst[31:20] == ELINK_ID) begin
         dst[31:20] = ~ELINK_ID;
      end
      return make_packet(dst[0], dst, rand_word());
   endfunction

   // ########################################
   // compare tasks
   // ########################################

   task automatic compare_packet(input string name, input emesh_packet_t act,
                                 input emesh_packet_t exp);
      check_count++;
      if (act !== exp) begin
         error_count++;
         $display("Error at %0t: %s is %h, expected %h", $time, name, act, exp);
      end
   endtask

   task automatic compare_clk_config(input string name, input clk_config_t act,
                                     input clk_config_t exp);
      check_count++;
      if (act !== exp) begin
         error_count++;
         $display("Error at %0t: %s is %h, expected %h", $time, name, act, exp);
      end
   endtask

   task automatic compare_chipid(input string name, input chipid_t act, input chipid_t exp);
      check_count++;
      if (act !== exp) begin
         error_count++;
         $display("Error at %0t: %s is %h, expected %h", $time, name, act, exp);
      end
   endtask

   task automatic compare_bit(input string name, input logic act, input logic exp);
      check_count++;
      if (act !== exp) begin
         error_count++;
         $display("Error at %0t: %s is %b, expected %b", $time, name, act, exp);
      end
   endtask

   // ########################################
   // channel and sequencing tasks
   // ########################################

   task automatic wait_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic apply_reset();
      reset    = 1'b1;
      in_valid = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;
      exp_q.delete();
      exp_en     = 1'b1;
      exp_clk    = 16'h0573;  // all clocks on at the slowest speed
      exp_chipid = 12'h808;
   endtask

   // holds one packet until accepted and returns 1 ns after the transfer edge
   task automatic send_packet(input emesh_packet_t p);
      logic accepted;
      logic first;
      accepted  = 1'b0;
      first     = 1'b1;
      in_packet = p;
      in_valid  = 1'b1;
      while (!accepted) begin
         @(negedge clk);
         if (first && is_cfg_write(p)) begin
            compare_bit("in_ready", in_ready, 1'b1);  // never stalled
         end
         first    = 1'b0;
         accepted = in_ready;
         @(posedge clk);
         #1;
      end
      in_valid = 1'b0;
      if (is_cfg_write(p)) begin
         case (p.dstaddr[7:2])
            REG_RESET: exp_en     = !p.data[0];
            REG_CLK:   exp_clk    = p.data[15:0];
            default:   exp_chipid = p.data[11:0];
         endcase
      end else begin
         exp_q.push_back(p);
      end
   endtask

   task automatic check_config();
      @(negedge clk);
      compare_bit("elink_en", elink_en, exp_en);
      compare_clk_config("clk_config", clk_config, exp_clk);
      compare_chipid("chipid", chipid, exp_chipid);
      @(posedge clk);
      #1;
   endtask

   // the monitor pops at negedges, so the queue is polled at posedges
   task automatic wait_drain();
      while (exp_q.size() != 0) @(posedge clk);
      @(posedge clk);
      #1;
   endtask

   task automatic report_test(input string name, input int errors_before);
      test_count++;
      if (error_count == errors_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, error_count - errors_before);
      end
   endtask

   // ########################################
   // output monitor and out_ready driver
   // ########################################

   initial begin
      forever begin
         @(negedge clk);  // mid cycle when all outputs have settled
         if (!reset && out_valid && !exp_en) begin
            error_count++;
            $display("out_valid went high at %0t while the link was disabled", $time);
         end
         if (!reset && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
               error_count++;
               $display("a packet appeared on the output at %0t with none expected", $time);
            end else begin
               compare_packet("out_packet", out_packet, exp_q.pop_front());
            end
         end
      end
   end

   initial begin
      logic [1:0] mode;
      forever begin
         @(posedge clk);
         mode = ready_mode;  // tests change it 1 ns after an edge
         #1;
         if (mode == 2'd2) begin
            ready_state = xorshift32(ready_state);
            out_ready   = ready_state[4];
         end else begin
            out_ready = (mode == 2'd0);
         end
      end
   end

   // ########################################
   // tests
   // ########################################

   task automatic test_reset_values();
      int errs;
      errs = error_count;
      @(negedge clk);
      compare_bit("elink_en", elink_en, 1'b1);
      compare_clk_config("clk_config", clk_config, 16'h0573);
      compare_chipid("chipid", chipid, 12'h808);
      compare_bit("out_valid", out_valid, 1'b0);
      @(posedge clk);
      #1;
      report_test("reset_values", errs);
   endtask

   task automatic test_cfg_writes();
      int errs;
      errs = error_count;
      for (int i = 0; i < 4; i++) begin
         send_packet(make_packet(1'b1, build_addr(ELINK_ID, CFG_GROUP, REG_CLK), rand_word()));
         check_config();
         send_packet(make_packet(1'b1, build_addr(ELINK_ID, CFG_GROUP, REG_CHIPID), rand_word()));
         check_config();
      end
      wait_cycles(4);  // monitor flags any leak
      report_test("cfg_writes", errs);
   endtask

   task automatic test_pass_through();
      int errs;
      errs = error_count;
      send_packet(make_packet(1'b1, build_addr(~ELINK_ID, CFG_GROUP, REG_CLK), rand_word()));
      send_packet(make_packet(1'b1, build_addr(ELINK_ID, ~CFG_GROUP, REG_CLK), rand_word()));
      send_packet(make_packet(1'b1, build_addr(ELINK_ID, CFG_GROUP, 6'd9), rand_word()));
      // config space reads are forwarded and never answered
      send_packet(make_packet(1'b0, build_addr(ELINK_ID, CFG_GROUP, REG_RESET), rand_word()));
      send_packet(make_packet(1'b0, build_addr(ELINK_ID, CFG_GROUP, REG_CLK), rand_word()));
      send_packet(make_packet(1'b0, build_addr(ELINK_ID, CFG_GROUP, REG_CHIPID), rand_word()));
      for (int i = 0; i < 4; i++) begin
         send_packet(random_packet());
      end
      wait_drain();
      check_config();  // nothing above touches the registers
      report_test("pass_through", errs);
   endtask

   task automatic test_link_disable();
      int          errs;
      logic [31:0] r;
      errs = error_count;
      r    = rand_word();
      send_packet(make_packet(1'b1, build_addr(ELINK_ID, CFG_GROUP, REG_RESET), {r[31:1], 1'b1}));
      check_config();
      for (int i = 0; i < 3; i++) begin
         send_packet(random_packet());
      end
      repeat (10) begin
         @(negedge clk);
         compare_bit("out_valid", out_valid, 1'b0);  // held in the fifo
      end
      @(posedge clk);
      #1;
      r = rand_word();
      send_packet(make_packet(1'b1, build_addr(ELINK_ID, CFG_GROUP, REG_RESET), {r[31:1], 1'b0}));
      check_config();
      wait_drain();  // held packets come out in order
      report_test("link_disable", errs);
   endtask

   task automatic test_back_pressure();
      int errs;
      errs       = error_count;
      ready_mode = 2'd1;
      wait_cycles(2);
      for (int i = 0; i < 4; i++) begin
         send_packet(random_packet());  // fifo now full
      end
      in_packet = random_packet();  // shown without valid
      @(negedge clk);
      compare_bit("in_ready", in_ready, 1'b0);
      @(posedge clk);
      #1;
      send_packet(make_packet(1'b1, build_addr(ELINK_ID, CFG_GROUP, REG_CLK), rand_word()));
      check_config();
      ready_mode = 2'd2;
      for (int i = 0; i < 40; i++) begin
         send_packet(random_packet());
      end
      wait_drain();
      ready_mode = 2'd0;
      wait_cycles(2);
      report_test("back_pressure", errs);
   endtask

   task automatic test_reset_restore();
      int          errs;
      logic [31:0] r;
      errs = error_count;
      r    = rand_word();
      send_packet(make_packet(1'b1, build_addr(ELINK_ID, CFG_GROUP, REG_CLK), rand_word()));
      send_packet(make_packet(1'b1, build_addr(ELINK_ID, CFG_GROUP, REG_CHIPID), rand_word()));
      send_packet(make_packet(1'b1, build_addr(ELINK_ID, CFG_GROUP, REG_RESET), {r[31:1], 1'b1}));
      check_config();
      apply_reset();
      check_config();  // model back at reset values
      report_test("reset_restore", errs);
   endtask

   // ########################################
   // main sequence and timeout
   // ########################################

   initial begin
      reset       = 1'b1;
      in_valid    = 1'b0;
      in_packet   = '0;
      out_ready   = 1'b1;
      ready_mode  = 2'd0;
      data_state  = SEED;
      ready_state = xorshift32(SEED);
      check_count = 0;
      error_count = 0;
      test_count  = 0;
      apply_reset();
      test_reset_values();
      test_cfg_writes();
      test_pass_through();
      test_link_disable();
      test_back_pressure();
      test_reset_restore();
      $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
      if (error_count == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < MAX_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* src/elink_tx_top.sv */
// transmit config front end, top level
// config register block feeding the tx fifo
`timescale 1ns/1ps
`default_nettype none

module elink_tx_top (
   input  logic                        clk,
   input  logic                        reset,
   // mesh write channel in
   input  logic                        in_valid,
   output logic                        in_ready,
   input  emesh_pkg::emesh_packet_t    in_packet,
   // filtered channel out
   output logic                        out_valid,
   input  logic                        out_ready,
   output emesh_pkg::emesh_packet_t    out_packet,
   // config outputs
   output logic                        elink_en,
   output elink_cfg_pkg::clk_config_t  clk_config,
   output elink_cfg_pkg::chipid_t      chipid
);

   import emesh_pkg::*;

   // cfg block to fifo
   logic          fwd_valid;
   logic          fwd_ready;
   emesh_packet_t fwd_packet;

   // ########################################
   // config decode and filter
   // ########################################

   elink_cfg_regs u_cfg_regs (
      .clk        (clk),
      .reset      (reset),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .in_packet  (in_packet),
      .fwd_valid  (fwd_valid),
      .fwd_ready  (fwd_ready),
      .fwd_packet (fwd_packet),
      .elink_en   (elink_en),
      .clk_config (clk_config),
      .chipid     (chipid)
   );

   // ########################################
   // transmit buffer
   // ########################################

   // master enable gates the fifo head
   tx_write_fifo u_tx_fifo (
      .clk        (clk),
      .reset      (reset),
      .enable     (elink_en),
      .in_valid   (fwd_valid),
      .in_ready   (fwd_ready),
      .in_packet  (fwd_packet),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_packet (out_packet)
   );

endmodule

`default_nettype wire

/* src/tx_write_fifo.sv */
// transmit packet fifo, circular buffer with occupancy count
// head is hidden while the link is disabled
`timescale 1ns/1ps
`default_nettype none

module tx_write_fifo (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      enable,     // link master enable
   // write side
   input  logic                      in_valid,
   output logic                      in_ready,
   input  emesh_pkg::emesh_packet_t  in_packet,
   // read side, towards the serializer
   output logic                      out_valid,
   input  logic                      out_ready,
   output emesh_pkg::emesh_packet_t  out_packet
);

   import emesh_pkg::*;
   import elink_cfg_pkg::*;

   localparam int PTR_W = $clog2(TX_FIFO_DEPTH);
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(TX_FIFO_DEPTH - 1);
   localparam logic [PTR_W:0]   FULL_CNT = (PTR_W + 1)'(TX_FIFO_DEPTH);

   logic [PACKET_W-1:0] mem [TX_FIFO_DEPTH];  // packet storage

   logic [PTR_W-1:0] wr_ptr;   // next slot to fill
   logic [PTR_W-1:0] rd_ptr;   // oldest entry
   logic [PTR_W:0]   count;    // 0 .. depth
   logic             empty;
   logic             full;
   logic             push;
   logic             pop;

   // ########################################
   // status and handshakes
   // ########################################

   assign empty = (count == '0);
   assign full  = (count == FULL_CNT);

   assign in_ready  = !full;
   assign out_valid = !empty && enable;  // drops with enable, no xfer lost

   assign push = in_valid && in_ready;
   assign pop  = out_valid && out_ready;

   // ########################################
   // storage
   // ########################################

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_packet;
      end
   end

   assign out_packet = emesh_packet_t'(mem[rd_ptr]);

   // ########################################
   // pointers and count
   // ########################################

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // idle or push+pop
         endcase
      end
   end

   // ########################################
   // checks
   // ########################################

   // occupancy never beyond the buffer size
   a_no_overflow: assert property (@(posedge clk) disable iff (reset)
      count <= FULL_CNT)
      else $error("tx fifo overflow");

   // empty or full means the pointers meet, else a pop went past the tail
   a_no_underflow: assert property (@(posedge clk) disable iff (reset)
      (empty || full) |-> (rd_ptr == wr_ptr))
      else $error("tx fifo pointers out of step");

   // stalled head keeps its payload
   a_out_stable: assert property (@(posedge clk) disable iff (reset)
      (out_valid && !out_ready) |=> $stable(out_packet))
      else $error("out_packet changed while stalled");

endmodule

`default_nettype wire

/* src/elink_cfg_regs.sv */
// link configuration registers: address decode, write capture
// and removal of config writes from the transmit stream
`timescale 1ns/1ps
`default_nettype none

module elink_cfg_regs (
   input  logic                        clk,
   input  logic                        reset,
   // packets from the mesh
   input  logic                        in_valid,
   output logic                        in_ready,
   input  emesh_pkg::emesh_packet_t    in_packet,
   // everything that is not a config write
   output logic                        fwd_valid,
   input  logic                        fwd_ready,
   output emesh_pkg::emesh_packet_t    fwd_packet,
   // register outputs
   output logic                        elink_en,
   output elink_cfg_pkg::clk_config_t  clk_config,
   output elink_cfg_pkg::chipid_t      chipid
);

   import emesh_pkg::*;
   import elink_cfg_pkg::*;

   emesh_addr_t dstaddr;     // address of the current packet
   reg_idx_t    reg_idx;     // word index inside the group
   logic        cfg_hit;     // own id and config group
   logic        reset_sel;
   logic        clk_sel;
   logic        chipid_sel;
   logic        cfg_write;   // write to an existing register
   logic        cfg_load;    // accepted config write

   logic        reset_reg;   // 1 holds the link off
   clk_config_t clk_reg;
   chipid_t     chipid_reg;

   // ########################################
   // address decode
   // ########################################

   assign dstaddr = in_packet.dstaddr;
   assign reg_idx = dstaddr[7:2];

   assign cfg_hit = (dstaddr[31:20] == ELINK_ID) &&
                    (dstaddr[10:8] == CFG_GROUP);

   assign reset_sel  = (reg_idx == REG_RESET);
   assign clk_sel    = (reg_idx == REG_CLK);
   assign chipid_sel = (reg_idx == REG_CHIPID);

   // reads and unused indices fall through to the fifo
   assign cfg_write = in_packet.write && cfg_hit &&
                      (reset_sel || clk_sel || chipid_sel);

   // ########################################
   // stream filter
   // ########################################

   // config writes are always absorbed, others see fifo ready
   assign in_ready   = cfg_write ? 1'b1 : fwd_ready;
   assign fwd_valid  = in_valid && !cfg_write;
   assign fwd_packet = in_packet;  // no reformatting

   assign cfg_load = in_valid && cfg_write;  // ready is 1 here

   // ########################################
   // registers
   // ########################################

   always_ff @(posedge clk) begin
      if (reset) begin
         reset_reg  <= 1'b0;            // link enabled out of reset
         clk_reg    <= CLK_CONFIG_RESET;
         chipid_reg <= CHIPID_RESET;
      end else if (cfg_load) begin
         if (reset_sel) begin
            reset_reg <= in_packet.data[0];
         end
         if (clk_sel) begin
            clk_reg <= in_packet.data[15:0];
         end
         if (chipid_sel) begin
            chipid_reg <= in_packet.data[11:0];
         end
      end
   end

   assign elink_en   = !reset_reg;  // master enable, active high
   assign clk_config = clk_reg;
   assign chipid     = chipid_reg;

   // ########################################
   // checks
   // ########################################

   // rule rebuilt from the raw packet fields
   logic is_cfg_wr;

   assign is_cfg_wr = in_packet.write &&
                      (in_packet.dstaddr[31:20] == ELINK_ID) &&
                      (in_packet.dstaddr[10:8] == CFG_GROUP) &&
                      (in_packet.dstaddr[7:2] inside {REG_RESET, REG_CLK, REG_CHIPID});

   // a config write never leaks into the tx fifo
   a_no_fwd_cfg: assert property (@(posedge clk) disable iff (reset)
      (in_valid && is_cfg_wr) |-> !fwd_valid)
      else $error("config write forwarded");

   // config writes get through even with a full fifo
   a_cfg_ready: assert property (@(posedge clk) disable iff (reset)
      is_cfg_wr |-> in_ready)
      else $error("config write stalled");

endmodule

`default_nettype wire

/* src/elink_cfg_pkg.sv */
// link configuration space
// node id, register group and indices, reset values, register types
`default_nettype none

package elink_cfg_pkg;

   // ########################################
   // register types
   // ########################################

   typedef logic [5:0]  reg_idx_t;     // word index, dstaddr[7:2]
   typedef logic [15:0] clk_config_t;  // pll control word
   typedef logic [11:0] chipid_t;      // mesh coordinates of this chip

   // ########################################
   // address map
   // ########################################

   localparam logic [11:0] ELINK_ID  = 12'h000;  // vs dstaddr[31:20]
   localparam logic [2:0]  CFG_GROUP = 3'h2;     // vs dstaddr[10:8]

   localparam reg_idx_t REG_RESET  = 6'd0;  // bit 0 holds link in reset
   localparam reg_idx_t REG_CLK    = 6'd1;
   localparam reg_idx_t REG_CHIPID = 6'd2;

   // ########################################
   // reset values
   // ########################################

   // all clocks on, lowest speed
   localparam clk_config_t CLK_CONFIG_RESET = 16'h0573;
   localparam chipid_t     CHIPID_RESET     = 12'h808;

   // tx buffering
   localparam int TX_FIFO_DEPTH = 4;  // entries, power of two

endpackage

`default_nettype wire

/* src/emesh_pkg.sv */
// mesh packet format
// field types and the packed write packet struct
`default_nettype none

package emesh_pkg;

   // ########################################
   // widths and field types
   // ########################################

   localparam int PACKET_W = 104;      // write + modes + dst + data + src

   typedef logic [31:0] emesh_addr_t;  // byte address on the mesh
   typedef logic [31:0] emesh_data_t;  // write data or read return addr
   typedef logic [1:0]  datamode_t;    // 0 byte .. 3 double
   typedef logic [4:0]  ctrlmode_t;    // routing and special ops

   // ########################################
   // packet layout, msb first
   // ########################################

   // one packet per valid/ready transfer
   typedef struct packed {
      logic        write;     // 1 write, 0 read
      datamode_t   datamode;  // access size
      ctrlmode_t   ctrlmode;
      emesh_addr_t dstaddr;   // chip id in [31:20]
      emesh_data_t data;
      emesh_addr_t srcaddr;   // return address for reads
   } emesh_packet_t;

endpackage

`default_nettype wire
